/* src/i2c_pkg.sv */
package i2c_pkg;

    // ====================
    // Widths
    // ====================
    localparam int ADDR_BITS = 7;   // 7-bit target address
    localparam int BYTE_BITS = 8;   // Data byte, also address plus R/W

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BYTE_BITS-1:0] byte_t;
    typedef logic [2:0]           bit_cnt_t;   // Bit index within a byte

    // R/W bit, LSB of the address byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // ====================
    // Controller states
    // ====================
    typedef enum logic [2:0] {
        IDLE      = 3'd0,   // Bus free, waiting for START
        START     = 3'd1,   // START seen, waiting for SCL low
        ADDR_RCV  = 3'd2,   // Shifting in address and R/W
        ADDR_ACK  = 3'd3,   // Ninth clock of the address byte
        DATA_RCV  = 3'd4,   // Write byte coming in
        DATA_SEND = 3'd5,   // Read byte going out
        DATA_ACK  = 3'd6,   // Ninth clock of the data byte
        WAIT_STOP = 3'd7    // Done, STOP or repeated START next
    } i2c_state_t;

    // Sampled bus events, sampler to controller, one cycle each
    typedef struct packed {
        logic scl_rise;   // SCL rising edge
        logic scl_fall;   // SCL falling edge
        logic start;      // SDA fell with SCL high
        logic stop;       // SDA rose with SCL high
        logic sda;        // Synchronised SDA level
    } bus_event_t;

endpackage

/* src/i2c_line_sampler.sv */
`timescale 1ns/1ps

module i2c_line_sampler #(
    parameter int SYNC_STAGES = 3   // Synchroniser depth, 2 or more
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scl,       // Raw bus clock, async
    input  logic                sda_in,    // Raw resolved data line, async
    output i2c_pkg::bus_event_t bus_evt
);

    // ====================
    // Synchroniser
    // ====================
    // Both lines travel side by side, bit 1 SCL and bit 0 SDA
    logic [SYNC_STAGES-1:0][1:0] sync_q;

    logic scl_s;      // Synchronised SCL
    logic sda_s;      // Synchronised SDA
    logic scl_prev;   // SCL one cycle back
    logic sda_prev;   // SDA one cycle back
    logic start_q;    // Registered START flag
    logic stop_q;     // Registered STOP flag

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '1;   // Idle bus reads high
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], {scl, sda_in}};
        end
    end

    assign scl_s = sync_q[SYNC_STAGES-1][1];
    assign sda_s = sync_q[SYNC_STAGES-1][0];

    // ====================
    // Edge history
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_prev <= scl_s;
            sda_prev <= sda_s;
        end
    end

    // START and STOP need SCL high before and after the SDA edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
        end else begin
            start_q <= scl_s & scl_prev & sda_prev & ~sda_s;   // SDA fall
            stop_q  <= scl_s & scl_prev & ~sda_prev & sda_s;   // SDA rise
        end
    end

    // SCL edges straight off the last stage, START/STOP one cycle later
    assign bus_evt.scl_rise = scl_s & ~scl_prev;
    assign bus_evt.scl_fall = ~scl_s & scl_prev;
    assign bus_evt.start    = start_q;
    assign bus_evt.stop     = stop_q;
    assign bus_evt.sda      = sda_s;

    // SCL still high when the delayed START or STOP arrives
    a_start_stop_before_fall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus_evt.start || bus_evt.stop) |-> !bus_evt.scl_fall
    ) else $error("START or STOP flagged on an SCL fall");

endmodule

/* src/i2c_target_ctrl.sv */
`timescale 1ns/1ps

module i2c_target_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  i2c_pkg::bus_event_t bus_evt,        // From the line sampler
    input  i2c_pkg::addr_t      target_addr,    // Our address, quasi-static
    input  i2c_pkg::byte_t      tx_data,        // Byte returned on a read
    output i2c_pkg::byte_t      rx_data,        // Byte received on a write
    output logic                rx_valid,       // One-cycle strobe for rx_data
    output logic                sda_pull_low    // High pulls SDA to 0
);

    localparam int MSB = i2c_pkg::BYTE_BITS - 1;
    localparam i2c_pkg::bit_cnt_t LAST_BIT = i2c_pkg::bit_cnt_t'(MSB);

    // ====================
    // State and registers
    // ====================
    i2c_pkg::i2c_state_t state, state_next;
    i2c_pkg::bit_cnt_t   bit_cnt, bit_cnt_next;   // Counts SCL rises in a byte
    logic                pull_next;
    logic                rx_valid_next;
    i2c_pkg::byte_t      rx_data_next;

    // Shift registers, payload only
    i2c_pkg::byte_t addr_sh, addr_sh_next;   // Address plus R/W
    i2c_pkg::byte_t rx_sh, rx_sh_next;       // Incoming write byte
    i2c_pkg::byte_t tx_sh, tx_sh_next;       // Outgoing read byte

    logic           rw;        // R/W of the current transfer
    logic           addr_hit;  // Upper 7 address bits match
    i2c_pkg::byte_t rx_byte;   // Write byte including the bit on the line

    assign rw       = addr_sh[0];
    assign addr_hit = (addr_sh[i2c_pkg::ADDR_BITS-1:0] == target_addr);
    assign rx_byte  = {rx_sh[MSB-1:0], bus_evt.sda};

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_next    = state;
        bit_cnt_next  = bit_cnt;
        pull_next     = sda_pull_low;
        rx_valid_next = 1'b0;         // Strobe, default low
        rx_data_next  = rx_data;
        addr_sh_next  = addr_sh;
        rx_sh_next    = rx_sh;
        tx_sh_next    = tx_sh;

        if (bus_evt.stop) begin
            // STOP wins from any state
            state_next = i2c_pkg::IDLE;
            pull_next  = 1'b0;
        end else if (bus_evt.start) begin
            // First START or repeated START
            state_next = i2c_pkg::START;
            pull_next  = 1'b0;
        end else begin
            case (state)
                i2c_pkg::IDLE: begin
                    pull_next = 1'b0;   // Line released
                end

                i2c_pkg::START: begin
                    // Controller pulls SCL low before the first address bit
                    if (bus_evt.scl_fall) begin
                        state_next   = i2c_pkg::ADDR_RCV;
                        bit_cnt_next = '0;
                    end
                end

                i2c_pkg::ADDR_RCV: begin
                    if (bus_evt.scl_rise) begin
                        addr_sh_next = {addr_sh[MSB-1:0], bus_evt.sda};   // MSB first
                        bit_cnt_next = bit_cnt + 3'd1;                    // Wraps to 0
                        if (bit_cnt == LAST_BIT) begin
                            // addr_sh still holds the 7 address bits here
                            if (addr_hit) begin
                                state_next = i2c_pkg::ADDR_ACK;
                            end else begin
                                state_next = i2c_pkg::WAIT_STOP;   // Not us, stay off SDA
                            end
                        end
                    end
                end

                i2c_pkg::ADDR_ACK: begin
                    // First fall starts the ACK, second fall ends it
                    if (bus_evt.scl_fall) begin
                        if (!sda_pull_low) begin
                            pull_next = 1'b1;   // ACK
                        end else if (rw == i2c_pkg::RW_READ) begin
                            tx_sh_next = tx_data;     // Capture read byte
                            pull_next  = ~tx_data[MSB];
                            state_next = i2c_pkg::DATA_SEND;
                        end else begin
                            pull_next  = 1'b0;
                            state_next = i2c_pkg::DATA_RCV;
                        end
                    end
                end

                i2c_pkg::DATA_RCV: begin
                    if (bus_evt.scl_rise) begin
                        rx_sh_next   = rx_byte;
                        bit_cnt_next = bit_cnt + 3'd1;
                        if (bit_cnt == LAST_BIT) begin
                            rx_data_next  = rx_byte;   // Whole byte out
                            rx_valid_next = 1'b1;
                            state_next    = i2c_pkg::DATA_ACK;
                        end
                    end
                end

                i2c_pkg::DATA_SEND: begin
                    // Next bit after each fall, released line for a 1
                    if (bus_evt.scl_fall) begin
                        tx_sh_next = {tx_sh[MSB-1:0], 1'b0};
                        pull_next  = ~tx_sh[MSB-1];
                    end
                    if (bus_evt.scl_rise) begin
                        bit_cnt_next = bit_cnt + 3'd1;
                        if (bit_cnt == LAST_BIT) begin
                            state_next = i2c_pkg::DATA_ACK;   // Eighth bit sampled
                        end
                    end
                end

                i2c_pkg::DATA_ACK: begin
                    if (rw == i2c_pkg::RW_WRITE) begin
                        // Our ACK for the write byte
                        if (bus_evt.scl_fall) begin
                            if (!sda_pull_low) begin
                                pull_next = 1'b1;
                            end else begin
                                pull_next  = 1'b0;
                                state_next = i2c_pkg::WAIT_STOP;
                            end
                        end
                    end else begin
                        // Controller's ACK or NACK, either ends a single byte read
                        if (bus_evt.scl_fall) begin
                            pull_next = 1'b0;   // Hand SDA to the controller
                        end
                        if (bus_evt.scl_rise) begin
                            state_next = i2c_pkg::WAIT_STOP;
                        end
                    end
                end

                i2c_pkg::WAIT_STOP: begin
                    pull_next = 1'b0;   // Only START or STOP move us on
                end

                default: begin
                    state_next = i2c_pkg::IDLE;
                    pull_next  = 1'b0;
                end
            endcase
        end
    end

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= i2c_pkg::IDLE;
            bit_cnt      <= '0;
            sda_pull_low <= 1'b0;   // Bus released
            rx_valid     <= 1'b0;
            rx_data      <= '0;
        end else begin
            state        <= state_next;
            bit_cnt      <= bit_cnt_next;
            sda_pull_low <= pull_next;
            rx_valid     <= rx_valid_next;
            rx_data      <= rx_data_next;
        end
    end

    always_ff @(posedge clk) begin
        addr_sh <= addr_sh_next;
        rx_sh   <= rx_sh_next;
        tx_sh   <= tx_sh_next;
    end

    // Strobe, one cycle per received byte
    a_rx_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    ) else $error("rx_valid high for two cycles");

    // Every path into IDLE or WAIT_STOP must release SDA on the same edge
    a_released_when_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == i2c_pkg::IDLE || state == i2c_pkg::WAIT_STOP) |-> !sda_pull_low
    ) else $error("SDA pulled low in IDLE or WAIT_STOP");

endmodule

/* src/i2c_target.sv */
`timescale 1ns/1ps

module i2c_target #(
    parameter int SYNC_STAGES = 3   // Synchroniser depth, 2 or more
) (
    input  logic           clk,
    input  logic           rst_n,

    // ====================
    // I2C lines
    // ====================
    input  logic           scl,            // Raw SCL
    input  logic           sda_in,         // Resolved SDA level
    output logic           sda_pull_low,   // Open-drain pull on SDA

    // ====================
    // User side
    // ====================
    input  i2c_pkg::addr_t target_addr,    // Our 7-bit address
    input  i2c_pkg::byte_t tx_data,        // Read data
    output i2c_pkg::byte_t rx_data,        // Write data
    output logic           rx_valid        // rx_data strobe
);

    // Sampled edges and levels, one cycle per event
    i2c_pkg::bus_event_t bus_evt;

    // Input side
    i2c_line_sampler #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_line_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .scl     (scl),
        .sda_in  (sda_in),
        .bus_evt (bus_evt)
    );

    // Transaction FSM, drives SDA and the user outputs
    i2c_target_ctrl u_target_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_evt      (bus_evt),
        .target_addr  (target_addr),
        .tx_data      (tx_data),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .sda_pull_low (sda_pull_low)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,   // Clock period
    parameter int RESET_CYCLES = 5      // Clocks with rst_n low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* bench/tb_i2c_target.sv */
`timescale 1ns/1ps

module tb_i2c_target;

    // ====================
    // Setup
    // ====================
    localparam int CLK_PERIOD_NS = 100;
    localparam int HALF_CLKS     = 12;              // SCL half period in clocks
    localparam int QUARTER_CLKS  = HALF_CLKS / 2;
    localparam int SCL_PERIOD_NS = 2 * HALF_CLKS * CLK_PERIOD_NS;
    localparam int NUM_RANDOM    = 40;
    localparam int NUM_DIRECTED  = 7;
    localparam int NUM_TRANS     = NUM_RANDOM + NUM_DIRECTED;
    localparam int MARGIN_NS     = NUM_TRANS * 4 * SCL_PERIOD_NS + 100 * CLK_PERIOD_NS;
    localparam int WATCHDOG_NS   = NUM_TRANS * 20 * SCL_PERIOD_NS + MARGIN_NS;

    logic           clk;
    logic           rst_n;
    logic           scl_ctl;        // Controller side of SCL, 1 releases
    logic           sda_ctl;        // Controller side of SDA, 1 releases
    logic           sda_line;       // Resolved open-drain SDA
    logic           sda_pull_low;
    i2c_pkg::addr_t target_addr;
    i2c_pkg::byte_t tx_data;
    i2c_pkg::byte_t rx_data;
    logic           rx_valid;

    integer         seed;
    logic [31:0]    rnd;
    logic [31:0]    rnd_data;
    int             errors;
    int             checks;
    int             rx_count = 0;     // rx_valid cycles seen so far
    int             pull_count = 0;   // Cycles with SDA pulled by the target
    i2c_pkg::byte_t rx_last;          // rx_data at the last strobe
    i2c_pkg::addr_t foreign;

    // Wired AND on SDA, target never stretches SCL
    assign sda_line = sda_ctl & ~sda_pull_low;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    i2c_target #(
        .SYNC_STAGES (3)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .scl          (scl_ctl),
        .sda_in       (sda_line),
        .sda_pull_low (sda_pull_low),
        .target_addr  (target_addr),
        .tx_data      (tx_data),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid)
    );

    // Outputs sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rx_valid) begin
                rx_count <= rx_count + 1;
                rx_last  <= rx_data;
            end
            if (sda_pull_low) begin
                pull_count <= pull_count + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    // ====================
    // Bus controller
    // ====================
    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
        end
    endtask

    task automatic send_start();
        if (!scl_ctl) begin
            sda_ctl = 1'b1;   // Repeated START, lift SDA while SCL low
            wait_clocks(QUARTER_CLKS);
            scl_ctl = 1'b1;
            wait_clocks(HALF_CLKS);
        end
        sda_ctl = 1'b0;       // SDA falls with SCL high
        wait_clocks(HALF_CLKS);
        scl_ctl = 1'b0;
        wait_clocks(QUARTER_CLKS);
    endtask

    task automatic send_stop();
        sda_ctl = 1'b0;
        wait_clocks(QUARTER_CLKS);
        scl_ctl = 1'b1;
        wait_clocks(HALF_CLKS);
        sda_ctl = 1'b1;       // SDA rises with SCL high
        wait_clocks(HALF_CLKS);
    endtask

    // Entered and left with SCL low, a quarter period after the fall
    task automatic send_bit(input logic b);
        sda_ctl = b;
        wait_clocks(QUARTER_CLKS);
        scl_ctl = 1'b1;
        wait_clocks(HALF_CLKS);
        scl_ctl = 1'b0;
        wait_clocks(QUARTER_CLKS);
    endtask

    task automatic recv_bit(output logic b);
        sda_ctl = 1'b1;       // Hand SDA to the target
        wait_clocks(QUARTER_CLKS);
        scl_ctl = 1'b1;
        wait_clocks(QUARTER_CLKS);
        b = sda_line;         // Middle of the high phase
        wait_clocks(QUARTER_CLKS);
        scl_ctl = 1'b0;
        wait_clocks(QUARTER_CLKS);
    endtask

    task automatic send_byte(input i2c_pkg::byte_t data, output logic ack);
        int i;
        for (i = 7; i >= 0; i--) begin
            send_bit(data[i]);   // MSB first
        end
        recv_bit(ack);
    endtask

    task automatic recv_byte(output i2c_pkg::byte_t data, input logic nack);
        logic b;
        int   i;
        data = '0;
        for (i = 7; i >= 0; i--) begin
            recv_bit(b);
            data[i] = b;
        end
        send_bit(nack);
    endtask

    // ====================
    // Transactions and model
    // ====================
    task automatic write_transfer(input i2c_pkg::addr_t addr, input i2c_pkg::byte_t data,
                                  input logic with_stop);
        logic ack;
        logic hit;
        int   rx_base;
        int   pull_base;
        hit       = (addr == target_addr);   // ACK expected only on a match
        rx_base   = rx_count;
        pull_base = pull_count;
        send_start();
        send_byte({addr, i2c_pkg::RW_WRITE}, ack);
        check(32'(ack), 32'(!hit), "address ACK on write");
        if (hit) begin
            send_byte(data, ack);
            check(32'(ack), 32'd0, "data ACK on write");
            check(rx_count - rx_base, 1, "rx_valid pulses per byte");
            check(32'(rx_last), 32'(data), "rx_data");
        end
        if (with_stop || !hit) begin
            send_stop();
        end
        if (!hit) begin
            check(pull_count - pull_base, 0, "SDA pulled for a foreign address");
            check(rx_count - rx_base, 0, "rx_valid for a foreign address");
        end
    endtask

    task automatic read_transfer(input i2c_pkg::addr_t addr, input i2c_pkg::byte_t data);
        logic           ack;
        logic           hit;
        i2c_pkg::byte_t got;
        int             rx_base;
        int             pull_base;
        hit       = (addr == target_addr);
        rx_base   = rx_count;
        pull_base = pull_count;
        tx_data   = data;
        send_start();
        send_byte({addr, i2c_pkg::RW_READ}, ack);
        check(32'(ack), 32'(!hit), "address ACK on read");
        if (hit) begin
            recv_byte(got, 1'b1);   // NACK, single byte
            check(32'(got), 32'(data), "read byte");
        end
        send_stop();
        check(32'(sda_pull_low), 32'd0, "SDA released after read");
        check(rx_count - rx_base, 0, "rx_valid during read");
        if (!hit) begin
            check(pull_count - pull_base, 0, "SDA pulled for a foreign address");
        end
    endtask

    // STOP after four address bits
    task automatic abort_address(input i2c_pkg::addr_t addr);
        int i;
        int rx_base;
        int pull_base;
        rx_base   = rx_count;
        pull_base = pull_count;
        send_start();
        for (i = 6; i >= 3; i--) begin
            send_bit(addr[i]);
        end
        send_stop();
        check(pull_count - pull_base, 0, "SDA pulled after aborted address");
        check(rx_count - rx_base, 0, "rx_valid after aborted address");
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        seed        = 32'h23e9cc58;
        errors      = 0;
        checks      = 0;
        scl_ctl     = 1'b1;   // Idle bus
        sda_ctl     = 1'b1;
        target_addr = '0;
        tx_data     = '0;

        @(posedge rst_n);
        wait_clocks(HALF_CLKS);
        check(32'(sda_pull_low), 32'd0, "sda_pull_low after reset");
        check(32'(rx_valid), 32'd0, "rx_valid after reset");
        check(32'(rx_data), 32'd0, "rx_data after reset");

        rnd         = $random(seed);
        rnd_data    = $random(seed);
        target_addr = rnd[6:0];
        foreign     = target_addr ^ 7'h2a;   // Never equal to target_addr

        write_transfer(target_addr, rnd_data[7:0], 1'b1);
        read_transfer(target_addr, rnd_data[15:8]);
        write_transfer(foreign, rnd_data[23:16], 1'b1);
        write_transfer(target_addr, rnd_data[31:24], 1'b0);   // Repeated START next
        read_transfer(target_addr, rnd_data[7:0] ^ 8'hff);
        abort_address(target_addr);
        write_transfer(target_addr, rnd_data[15:8] ^ 8'h5a, 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd         = $random(seed);
            rnd_data    = $random(seed);
            target_addr = rnd[6:0];
            foreign     = target_addr ^ ((rnd[22:16] == 7'h00) ? 7'h01 : rnd[22:16]);
            case (rnd[9:8])
                2'd1: read_transfer(target_addr, rnd_data[15:8]);
                2'd2: begin
                    if (rnd[10]) begin
                        read_transfer(foreign, rnd_data[15:8]);
                    end else begin
                        write_transfer(foreign, rnd_data[7:0], 1'b1);
                    end
                end
                default: write_transfer(target_addr, rnd_data[7:0], 1'b1);
            endcase
            wait_clocks(HALF_CLKS);   // Bus free time
        end

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* src.f */
src/i2c_pkg.sv
src/i2c_line_sampler.sv
src/i2c_target_ctrl.sv
src/i2c_target.sv
bench/tb_clock.sv
bench/tb_i2c_target.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the I2C target testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_i2c_target -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0
